// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/icache_pkg.sv
      - design/tag_port_if.sv
      - design/icache_ctrl.sv
      - design/tag_port_arbiter.sv
      - design/tag_valid_array.sv
      - design/data_array.sv
      - design/victim_select.sv
      - design/icache_top.sv
  - target: test
    include_dirs:
      - design
      - dv
    files:
      - dv/tb_icache.sv

// ==== design/data_array.sv ====
/*
 * cache line store
 * reads all ways on a lookup and returns the fetched word of the hit way or the fill
 */
`include "icache_defines.svh"

module data_array (
  input  logic                  clk_i,
  input  logic                  rd_i,
  input  logic                  wr_i,
  input  icache_pkg::way_oh_t   way_i,
  input  icache_pkg::set_idx_t  idx_i,
  input  icache_pkg::line_t     wdata_i,
  input  icache_pkg::way_oh_t   hit_way_i,
  input  icache_pkg::word_sel_t word_sel_i,
  input  icache_pkg::line_t     fill_line_i,
  input  logic                  rd_from_fill_i,
  output icache_pkg::fetch_t    data_o
);

  icache_pkg::line_t mem_q   [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::line_t rdata_q [`ICACHE_WAYS];
  icache_pkg::line_t sel_line;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (wr_i && way_i[w]) begin
        mem_q[w][idx_i] <= wdata_i;
      end
      if (rd_i && way_i[w]) begin
        rdata_q[w] <= mem_q[w][idx_i];
      end
    end
  end

  // hit mask is one-hot, so an or-mux is enough
  always_comb begin
    sel_line = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (hit_way_i[w]) begin
        sel_line |= rdata_q[w];
      end
    end
    if (rd_from_fill_i) begin
      sel_line = fill_line_i;
    end
  end

  assign data_o = sel_line[word_sel_i*`ICACHE_FETCH_W +: `ICACHE_FETCH_W];

endmodule

// ==== design/icache_ctrl.sv ====
/*
 * instruction cache controller
 * lookup/refill FSM, valid-bit sweep, line and word requests to memory,
 * and the fill write into the victim way
 */
`include "icache_defines.svh"

module icache_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  en_i,
  input  logic                  flush_i,
  // fetch side
  input  logic                  req_i,
  input  icache_pkg::paddr_t    addr_i,
  output logic                  ready_o,
  output logic                  valid_o,
  output logic                  miss_o,
  // refill request and return
  output logic                  mem_req_o,
  output icache_pkg::paddr_t    mem_addr_o,
  output logic                  mem_nc_o,
  output icache_pkg::way_idx_t  mem_way_o,
  input  logic                  mem_ack_i,
  input  logic                  rtrn_fill_i,
  // lookup result and replacement choice
  input  logic                  hit_i,
  input  icache_pkg::way_idx_t  victim_way_i,
  // data array control
  output logic                  data_rd_o,
  output logic                  data_wr_o,
  output icache_pkg::way_oh_t   data_way_o,
  output icache_pkg::set_idx_t  data_idx_o,
  output icache_pkg::word_sel_t word_sel_o,
  // valid sweep
  output logic                  flush_en_o,
  output icache_pkg::set_idx_t  flush_idx_o,
  tag_port_if.requester         tag_port,
  output logic                  fill_wr_o,
  output logic                  rd_from_fill_o
);

  icache_pkg::ctrl_state_e state_d, state_q;
  icache_pkg::paddr_t      addr_d, addr_q;
  icache_pkg::way_idx_t    repl_way_d, repl_way_q;
  icache_pkg::way_oh_t     repl_oh;
  icache_pkg::set_idx_t    flush_cnt_d, flush_cnt_q;
  logic                    cache_en_d, cache_en_q;
  logic                    flush_d, flush_q;
  logic                    accept;
  logic                    paddr_nc;
  logic                    flush_done;

  ////////////////////////////////////////////////////////////////////////////
  // address register and request plumbing
  ////////////////////////////////////////////////////////////////////////////

  assign accept = ready_o & req_i;
  assign addr_d = accept ? addr_i : addr_q;

  // i/o space, or everything while disabled
  assign paddr_nc = ~cache_en_q | addr_q[`ICACHE_NC_BIT];

  // word address for nc, line address otherwise
  assign mem_addr_o = paddr_nc ? {addr_q[`ICACHE_ADDR_W-1:2], 2'b00} :
                                 {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                                  {`ICACHE_OFFSET_W{1'b0}}};
  assign mem_nc_o   = paddr_nc;

  // victim is taken during compare and held through the miss
  assign repl_way_d = (state_q == icache_pkg::READ) ? victim_way_i : repl_way_q;
  assign repl_oh    = icache_pkg::way_oh_t'(1) << repl_way_q;
  assign mem_way_o  = repl_way_d;

  // lookups read all ways at the incoming index, fills write the victim
  assign data_rd_o  = accept;
  assign data_wr_o  = fill_wr_o;
  assign data_way_o = accept ? '1 : repl_oh;
  assign data_idx_o = accept ? addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W] :
                               addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  assign word_sel_o = addr_q[`ICACHE_OFFSET_W-1:2];

  // same index and way on the tag side
  assign tag_port.req      = accept ? '1 : (fill_wr_o ? repl_oh : '0);
  assign tag_port.we       = fill_wr_o;
  assign tag_port.idx      = data_idx_o;
  assign tag_port.wr_valid = 1'b1;
  assign tag_port.wr_tag   = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

  // sweep counter wraps back to set 0 on its last step
  assign flush_en_o  = (state_q == icache_pkg::FLUSH);
  assign flush_idx_o = flush_cnt_q;
  assign flush_done  = (flush_cnt_q == icache_pkg::set_idx_t'(`ICACHE_SETS-1));
  assign flush_cnt_d = flush_en_o ? flush_cnt_q + 1'b1 : flush_cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    // disabling takes effect at once, enabling goes through a sweep
    cache_en_d     = cache_en_q & en_i;
    flush_d        = flush_q | flush_i | (en_i & ~cache_en_q);
    ready_o        = 1'b0;
    valid_o        = 1'b0;
    miss_o         = 1'b0;
    mem_req_o      = 1'b0;
    fill_wr_o      = 1'b0;
    rd_from_fill_o = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      icache_pkg::FLUSH: begin
        if (flush_done) begin
          state_d    = icache_pkg::IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // an invalidation holding the tag port delays acceptance
      icache_pkg::IDLE: begin
        if (flush_d) begin
          state_d = icache_pkg::FLUSH;
        end else begin
          ready_o = tag_port.gnt;
          if (req_i && tag_port.gnt) begin
            state_d = icache_pkg::READ;
          end
        end
      end
      // compare cycle, a hit may accept the next fetch
      icache_pkg::READ: begin
        if (hit_i && !paddr_nc) begin
          valid_o = 1'b1;
          state_d = icache_pkg::IDLE;
          if (!flush_d) begin
            ready_o = tag_port.gnt;
            if (req_i && tag_port.gnt) begin
              state_d = icache_pkg::READ;
            end
          end
        end else begin
          // hold the request until memory takes it
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~paddr_nc;
            state_d = icache_pkg::MISS;
          end
        end
      end
      // wait for the fill, nc data is only forwarded
      icache_pkg::MISS: begin
        rd_from_fill_o = 1'b1;
        if (rtrn_fill_i) begin
          valid_o   = 1'b1;
          fill_wr_o = ~paddr_nc;
          state_d   = icache_pkg::IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q     <= addr_d;
    repl_way_q <= repl_way_d;
  end

endmodule

// ==== design/icache_defines.svh ====
/*
 * instruction cache geometry
 * four ways of sixteen sets with 128-bit lines on 32-bit physical fetch addresses
 */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// associativity and depth
`define ICACHE_WAYS 4
`define ICACHE_SETS 16

// line and fetch word
`define ICACHE_LINE_W 128
`define ICACHE_FETCH_W 32

// address split, tag | index | byte offset
`define ICACHE_ADDR_W 32
`define ICACHE_OFFSET_W 4
`define ICACHE_INDEX_W 4
`define ICACHE_TAG_W 24

// upper half of the address space is i/o and never cached
`define ICACHE_NC_BIT 31

`endif

// ==== design/icache_pkg.sv ====
/*
 * instruction cache types
 * vector types for addresses, tags and way masks, plus the FSM and return encodings
 */
`include "icache_defines.svh"

package icache_pkg;

  // address and its fields
  typedef logic [`ICACHE_ADDR_W-1:0]  paddr_t;
  typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] set_idx_t;
  // fetch word within a line
  typedef logic [$clog2(`ICACHE_LINE_W/`ICACHE_FETCH_W)-1:0] word_sel_t;

  // way selection, one-hot and binary
  typedef logic [`ICACHE_WAYS-1:0]         way_oh_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;

  // payload
  typedef logic [`ICACHE_LINE_W-1:0]  line_t;
  typedef logic [`ICACHE_FETCH_W-1:0] fetch_t;

  // what arrives on the return port
  typedef enum logic {
    RTRN_IFILL = 1'b0,
    RTRN_INV   = 1'b1
  } rtrn_type_e;

  // controller FSM
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

// ==== design/icache_top.sv ====
/*
 * instruction cache top level
 * controller, tag port arbiter, tag/valid and data arrays, replacement
 */
`include "icache_defines.svh"

module icache_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic                   flush_i,
  // fetch
  input  logic                   req_i,
  input  icache_pkg::paddr_t     addr_i,
  output logic                   ready_o,
  output logic                   valid_o,
  output icache_pkg::fetch_t     data_o,
  output logic                   miss_o,
  // refill request
  output logic                   mem_req_o,
  output icache_pkg::paddr_t     mem_addr_o,
  output logic                   mem_nc_o,
  output icache_pkg::way_idx_t   mem_way_o,
  input  logic                   mem_ack_i,
  // return port, fills and invalidations
  input  logic                   mem_rtrn_vld_i,
  input  icache_pkg::rtrn_type_e mem_rtrn_type_i,
  input  icache_pkg::line_t      mem_rtrn_data_i,
  input  icache_pkg::set_idx_t   inv_idx_i,
  input  logic                   inv_all_i,
  input  logic                   inv_way_vld_i,
  input  icache_pkg::way_idx_t   inv_way_i
);

  logic                  rtrn_fill;
  logic                  inv_vld;
  logic                  hit;
  logic                  data_rd;
  logic                  data_wr;
  logic                  flush_en;
  logic                  fill_wr;
  logic                  rd_from_fill;
  icache_pkg::way_oh_t   hit_way;
  icache_pkg::way_oh_t   way_valid;
  icache_pkg::way_oh_t   data_way;
  icache_pkg::way_idx_t  victim_way;
  icache_pkg::set_idx_t  data_idx;
  icache_pkg::set_idx_t  flush_idx;
  icache_pkg::word_sel_t word_sel;

  tag_port_if ctrl_port ();
  tag_port_if array_port ();

  // return port carries one or the other per cycle
  assign rtrn_fill = mem_rtrn_vld_i & (mem_rtrn_type_i == icache_pkg::RTRN_IFILL);
  assign inv_vld   = mem_rtrn_vld_i & (mem_rtrn_type_i == icache_pkg::RTRN_INV);

  ////////////////////////////////////////////////////////////////////////////
  // tag/valid store peers
  ////////////////////////////////////////////////////////////////////////////

  icache_ctrl i_icache_ctrl (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .en_i           ( en_i         ),
    .flush_i        ( flush_i      ),
    .req_i          ( req_i        ),
    .addr_i         ( addr_i       ),
    .ready_o        ( ready_o      ),
    .valid_o        ( valid_o      ),
    .miss_o         ( miss_o       ),
    .mem_req_o      ( mem_req_o    ),
    .mem_addr_o     ( mem_addr_o   ),
    .mem_nc_o       ( mem_nc_o     ),
    .mem_way_o      ( mem_way_o    ),
    .mem_ack_i      ( mem_ack_i    ),
    .rtrn_fill_i    ( rtrn_fill    ),
    .hit_i          ( hit          ),
    .victim_way_i   ( victim_way   ),
    .data_rd_o      ( data_rd      ),
    .data_wr_o      ( data_wr      ),
    .data_way_o     ( data_way     ),
    .data_idx_o     ( data_idx     ),
    .word_sel_o     ( word_sel     ),
    .flush_en_o     ( flush_en     ),
    .flush_idx_o    ( flush_idx    ),
    .tag_port       ( ctrl_port    ),
    .fill_wr_o      ( fill_wr      ),
    .rd_from_fill_o ( rd_from_fill )
  );

  tag_port_arbiter i_tag_port_arbiter (
    .flush_en_i    ( flush_en      ),
    .flush_idx_i   ( flush_idx     ),
    .inv_vld_i     ( inv_vld       ),
    .inv_idx_i     ( inv_idx_i     ),
    .inv_all_i     ( inv_all_i     ),
    .inv_way_vld_i ( inv_way_vld_i ),
    .inv_way_i     ( inv_way_i     ),
    .ctrl_port     ( ctrl_port     ),
    .array_port    ( array_port    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // arrays and replacement
  ////////////////////////////////////////////////////////////////////////////

  // lookup tag is the upper part of the registered fetch address
  tag_valid_array i_tag_valid_array (
    .clk_i     ( clk_i                                          ),
    .rst_ni    ( rst_ni                                         ),
    .port      ( array_port                                     ),
    .cmp_tag_i ( mem_addr_o[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W] ),
    .hit_o     ( hit                                            ),
    .hit_way_o ( hit_way                                        ),
    .valid_o   ( way_valid                                      )
  );

  data_array i_data_array (
    .clk_i          ( clk_i           ),
    .rd_i           ( data_rd         ),
    .wr_i           ( data_wr         ),
    .way_i          ( data_way        ),
    .idx_i          ( data_idx        ),
    .wdata_i        ( mem_rtrn_data_i ),
    .hit_way_i      ( hit_way         ),
    .word_sel_i     ( word_sel        ),
    .fill_line_i    ( mem_rtrn_data_i ),
    .rd_from_fill_i ( rd_from_fill    ),
    .data_o         ( data_o          )
  );

  victim_select i_victim_select (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .valid_i      ( way_valid  ),
    .fill_wr_i    ( fill_wr    ),
    .victim_way_o ( victim_way )
  );

endmodule

// ==== design/tag_port_arbiter.sv ====
/*
 * tag/valid store arbiter
 * fixed priority of sweep, then invalidation, then controller access
 */
module tag_port_arbiter (
  input  logic                 flush_en_i,
  input  icache_pkg::set_idx_t flush_idx_i,
  input  logic                 inv_vld_i,
  input  icache_pkg::set_idx_t inv_idx_i,
  input  logic                 inv_all_i,
  input  logic                 inv_way_vld_i,
  input  icache_pkg::way_idx_t inv_way_i,
  tag_port_if.arbiter          ctrl_port,
  tag_port_if.requester        array_port
);

  icache_pkg::way_oh_t inv_mask;

  // whole set, one way, or nothing
  assign inv_mask = inv_all_i     ? '1 :
                    inv_way_vld_i ? icache_pkg::way_oh_t'(1) << inv_way_i :
                                    '0;

  always_comb begin
    // tag only matters on a fill
    array_port.wr_tag = ctrl_port.wr_tag;
    if (flush_en_i) begin
      array_port.req      = '1;
      array_port.we       = 1'b1;
      array_port.idx      = flush_idx_i;
      array_port.wr_valid = 1'b0;
    end else if (inv_vld_i) begin
      array_port.req      = inv_mask;
      array_port.we       = 1'b1;
      array_port.idx      = inv_idx_i;
      array_port.wr_valid = 1'b0;
    end else begin
      array_port.req      = ctrl_port.req;
      array_port.we       = ctrl_port.we;
      array_port.idx      = ctrl_port.idx;
      array_port.wr_valid = ctrl_port.wr_valid;
    end
  end

  // controller only when the port is free
  assign ctrl_port.gnt = array_port.gnt & ~flush_en_i & ~inv_vld_i;

endmodule

// ==== design/tag_port_if.sv ====
/*
 * tag/valid store access port
 * one read or write of a set, masked per way, granted by the arbiter
 */
interface tag_port_if;

  // ways taking part, nonzero means an access
  icache_pkg::way_oh_t  req;
  logic                 we;
  icache_pkg::set_idx_t idx;
  // valid bit and tag for a write
  logic                 wr_valid;
  icache_pkg::tag_t     wr_tag;
  // access happens when req is nonzero and gnt is high
  logic                 gnt;

  modport requester (output req, we, idx, wr_valid, wr_tag, input gnt);
  modport arbiter (input req, we, idx, wr_valid, wr_tag, output gnt);
  modport array (input req, we, idx, wr_valid, wr_tag, output gnt);

endinterface

// ==== design/tag_valid_array.sv ====
/*
 * tag and valid store
 * one tag and valid bit per way and set, synchronous read, hit compare
 */
`include "icache_defines.svh"

module tag_valid_array (
  input  logic                clk_i,
  input  logic                rst_ni,
  tag_port_if.array           port,
  input  icache_pkg::tag_t    cmp_tag_i,
  output logic                hit_o,
  output icache_pkg::way_oh_t hit_way_o,
  output icache_pkg::way_oh_t valid_o
);

  icache_pkg::tag_t    tag_q      [`ICACHE_SETS][`ICACHE_WAYS];
  icache_pkg::way_oh_t valid_q    [`ICACHE_SETS];
  icache_pkg::tag_t    rd_tag_q   [`ICACHE_WAYS];
  icache_pkg::way_oh_t rd_valid_q;
  logic                access;

  // single requester behind the arbiter
  assign port.gnt = 1'b1;
  assign access   = (|port.req) & port.gnt;

  // valid bits and their readout
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '{default: '0};
      rd_valid_q <= '0;
    end else if (access) begin
      if (port.we) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          if (port.req[w]) begin
            valid_q[port.idx][w] <= port.wr_valid;
          end
        end
      end else begin
        rd_valid_q <= valid_q[port.idx];
      end
    end
  end

  // tags, only written when a line becomes valid
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (port.we) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
          if (port.req[w] && port.wr_valid) begin
            tag_q[port.idx][w] <= port.wr_tag;
          end
        end
      end else begin
        rd_tag_q <= tag_q[port.idx];
      end
    end
  end

  // compare against the registered lookup tag
  always_comb begin
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      hit_way_o[w] = rd_valid_q[w] & (rd_tag_q[w] == cmp_tag_i);
    end
  end

  assign hit_o   = |hit_way_o;
  assign valid_o = rd_valid_q;

endmodule

// ==== design/victim_select.sv ====
/*
 * replacement choice
 * lowest invalid way, or a 4-bit galois LFSR when the set is full
 */
`include "icache_defines.svh"

module victim_select (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  icache_pkg::way_oh_t  valid_i,
  input  logic                 fill_wr_i,
  output icache_pkg::way_idx_t victim_way_o
);

  // x^4 + x^3 + 1, maximal length
  localparam logic [3:0] LfsrTaps = 4'b1100;

  logic [3:0]           lfsr_q;
  logic                 all_valid;
  icache_pkg::way_idx_t inv_way;

  assign all_valid = &valid_i;

  // scan downwards so the lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS-1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = icache_pkg::way_idx_t'(w);
      end
    end
  end

  // step only on a fill into a full set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 4'b0001;
    end else if (fill_wr_i && all_valid) begin
      lfsr_q <= {1'b0, lfsr_q[3:1]} ^ (lfsr_q[0] ? LfsrTaps : 4'b0000);
    end
  end

  assign victim_way_o = all_valid ? lfsr_q[1:0] : inv_way;

endmodule

// ==== dv/tb_icache_tests.svh ====
/*
 * instruction cache directed tests
 * fetch helpers and one task per behavior
 */

// one fetch that waits for acceptance and valid_o and checks the word
task automatic fetch(input icache_pkg::paddr_t a, output int lat, output int reqs,
                     output int misses);
  int reqs_start;
  int misses_start;
  reqs_start   = req_count;
  misses_start = miss_count;
  @(negedge clk_i);
  req  = 1'b1;
  addr = a;
  #(ClkPeriod/4);
  while (!ready) begin
    @(negedge clk_i);
    #(ClkPeriod/4);
  end
  // accepted on the coming rising edge
  @(negedge clk_i);
  req = 1'b0;
  lat = 1;
  #(ClkPeriod/4);
  while (!valid) begin
    lat++;
    @(negedge clk_i);
    #(ClkPeriod/4);
  end
  check_value("data_o", expected_word(a), data);
  reqs   = req_count - reqs_start;
  misses = miss_count - misses_start;
endtask

task automatic expect_hit(input icache_pkg::paddr_t a);
  int lat;
  int reqs;
  int misses;
  fetch(a, lat, reqs, misses);
  check_value("mem_req_o count", 0, reqs);
  check_value("valid_o latency", 1, lat);
endtask

// miss_o only for cacheable refills
task automatic expect_miss(input icache_pkg::paddr_t a, input logic nc);
  int lat;
  int reqs;
  int misses;
  fetch(a, lat, reqs, misses);
  check_value("mem_req_o count", 1, reqs);
  check_value("mem_nc_o", nc, last_nc);
  // nc fetches ask for one word and cacheable ones for the whole line
  check_value("mem_addr_o", nc ? (a & 32'hFFFF_FFFC) : (a & 32'hFFFF_FFF0), last_addr);
  check_value("miss_o count", nc ? 0 : 1, misses);
endtask

// one cycle on the return port
task automatic invalidate(input icache_pkg::set_idx_t idx, input logic all,
                          input logic way_vld, input icache_pkg::way_idx_t way);
  @(negedge clk_i);
  inv_vld     = 1'b1;
  inv_idx     = idx;
  inv_all     = all;
  inv_way_vld = way_vld;
  inv_way     = way;
  @(negedge clk_i);
  inv_vld     = 1'b0;
  inv_all     = 1'b0;
  inv_way_vld = 1'b0;
endtask

task automatic miss_then_hit();
  int errs;
  errs = error_count;
  expect_miss(32'h0000_1234, 1'b0);
  expect_hit(32'h0000_1234);
  report_test("miss then hit", errs);
endtask

task automatic noncacheable_fetches();
  int errs;
  errs = error_count;
  // i/o space
  expect_miss(32'h8000_0048, 1'b1);
  expect_miss(32'h8000_0048, 1'b1);
  // cacheable space with the cache off
  @(negedge clk_i);
  en = 1'b0;
  expect_miss(32'h0000_0304, 1'b1);
  expect_miss(32'h0000_0304, 1'b1);
  // enabling again sweeps the whole cache
  @(negedge clk_i);
  en = 1'b1;
  report_test("non-cacheable fetches", errs);
endtask

task automatic invalidations();
  int                   errs;
  icache_pkg::way_idx_t way;
  errs = error_count;
  // set 5 is empty after the sweep, so the fill lands in way 0
  expect_miss(32'h0000_5058, 1'b0);
  check_value("mem_way_o", 0, last_way);
  way = last_way;
  expect_hit(32'h0000_5058);
  invalidate(4'd5, 1'b0, 1'b1, way);
  expect_miss(32'h0000_5058, 1'b0);
  // two ways of set 6 and then the whole set
  expect_miss(32'h0001_0060, 1'b0);
  expect_miss(32'h0002_0064, 1'b0);
  expect_hit(32'h0001_0060);
  expect_hit(32'h0002_0064);
  invalidate(4'd6, 1'b1, 1'b0, '0);
  expect_miss(32'h0001_0060, 1'b0);
  expect_miss(32'h0002_0064, 1'b0);
  report_test("invalidations", errs);
endtask

task automatic flush_clears();
  int                 errs;
  int                 low_cycles;
  icache_pkg::paddr_t lines [3];
  errs     = error_count;
  lines[0] = 32'h0000_4000;
  lines[1] = 32'h0000_4014;
  lines[2] = 32'h0000_4028;
  foreach (lines[k]) begin
    expect_miss(lines[k], 1'b0);
  end
  foreach (lines[k]) begin
    expect_hit(lines[k]);
  end
  @(negedge clk_i);
  flush = 1'b1;
  @(negedge clk_i);
  flush = 1'b0;
  // sweep of all sixteen sets
  low_cycles = 0;
  #(ClkPeriod/4);
  while (!ready) begin
    low_cycles++;
    @(negedge clk_i);
    #(ClkPeriod/4);
  end
  check_value("sweep cycles", 16, low_cycles);
  foreach (lines[k]) begin
    expect_miss(lines[k], 1'b0);
  end
  report_test("flush", errs);
endtask

task automatic replacement();
  int                 errs;
  int                 pick;
  int                 lat;
  int                 reqs;
  int                 misses;
  logic [5:0]         hit_mask;
  icache_pkg::paddr_t lines [6];
  errs = error_count;
  // six tags in set 9 are more than the four ways hold
  for (int k = 0; k < 6; k++) begin
    lines[k] = 32'h0000_0090 + (k + 1) * 32'h0000_1000 + 4 * (k % 4);
    expect_miss(lines[k], 1'b0);
  end
  hit_mask = '0;
  repeat (12) begin
    draw_bits(3, pick);
    while (pick > 5) begin
      draw_bits(3, pick);
    end
    fetch(lines[pick], lat, reqs, misses);
    if (reqs != 0) begin
      hit_mask = '0;
    end else begin
      hit_mask[pick] = 1'b1;
      check_value("valid_o latency", 1, lat);
      if ($countones(hit_mask) > 4) begin
        error_count++;
        $display("more than four lines of set 9 hit without a refill");
      end
    end
  end
  report_test("replacement", errs);
endtask

task automatic back_to_back_hits();
  int                 errs;
  int                 reqs_start;
  icache_pkg::paddr_t lines [8];
  errs = error_count;
  for (int k = 0; k < 8; k++) begin
    lines[k] = 32'h0000_70A0 + 16 * k + 4 * (k % 4);
    expect_miss(lines[k], 1'b0);
  end
  reqs_start = req_count;
  @(negedge clk_i);
  req  = 1'b1;
  addr = lines[0];
  #(ClkPeriod/4);
  while (!ready) begin
    @(negedge clk_i);
    #(ClkPeriod/4);
  end
  // each cycle returns one word and accepts the next address
  for (int k = 0; k < 8; k++) begin
    @(negedge clk_i);
    if (k < 7) begin
      addr = lines[k+1];
    end else begin
      req = 1'b0;
    end
    #(ClkPeriod/4);
    check_value("valid_o", 1, valid);
    check_value("data_o", expected_word(lines[k]), data);
    if (k < 7) begin
      check_value("ready_o", 1, ready);
    end
  end
  check_value("mem_req_o count", 0, req_count - reqs_start);
  report_test("back-to-back hits", errs);
endtask

// ==== dv/tb_icache.sv ====
/*
 * instruction cache testbench
 * clock, reset, refill memory model with random ack delay, checks and watchdog
 */
`include "icache_defines.svh"

module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod = 20;
  // worst case per fetch is a full sweep ahead of it and then the slowest refill
  localparam int FetchCycles = 25;
  localparam int SweepCycles = 20;
  // 58 fetches over all tests plus the sweeps after reset, re-enable and flush
  localparam int TestCycles = FetchCycles * 58 + SweepCycles * 3;
  localparam int TimeoutCycles = 2 * TestCycles;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   en;
  logic                   flush;
  logic                   req;
  icache_pkg::paddr_t     addr;
  logic                   ready;
  logic                   valid;
  icache_pkg::fetch_t     data;
  logic                   miss;
  logic                   mem_req;
  icache_pkg::paddr_t     mem_addr;
  logic                   mem_nc;
  icache_pkg::way_idx_t   mem_way;
  logic                   mem_ack;
  // return port carries fills from the model and invalidations from the tests
  logic                   fill_vld;
  icache_pkg::line_t      fill_line;
  logic                   inv_vld;
  logic                   rtrn_vld;
  icache_pkg::rtrn_type_e rtrn_type;
  icache_pkg::set_idx_t   inv_idx;
  logic                   inv_all;
  logic                   inv_way_vld;
  icache_pkg::way_idx_t   inv_way;

  // memory model bookkeeping
  int                     req_count;
  int                     miss_count;
  logic                   last_nc;
  icache_pkg::way_idx_t   last_way;
  icache_pkg::paddr_t     last_addr;
  logic [15:0]            lfsr_state = 16'd96;
  // results
  int                     error_count;
  int                     check_count;
  int                     test_count;
  int                     cycle_count;

  assign rtrn_vld  = fill_vld | inv_vld;
  assign rtrn_type = inv_vld ? icache_pkg::RTRN_INV : icache_pkg::RTRN_IFILL;

  icache_top i_icache_top (
    .clk_i           ( clk_i       ),
    .rst_ni          ( rst_ni      ),
    .en_i            ( en          ),
    .flush_i         ( flush       ),
    .req_i           ( req         ),
    .addr_i          ( addr        ),
    .ready_o         ( ready       ),
    .valid_o         ( valid       ),
    .data_o          ( data        ),
    .miss_o          ( miss        ),
    .mem_req_o       ( mem_req     ),
    .mem_addr_o      ( mem_addr    ),
    .mem_nc_o        ( mem_nc      ),
    .mem_way_o       ( mem_way     ),
    .mem_ack_i       ( mem_ack     ),
    .mem_rtrn_vld_i  ( rtrn_vld    ),
    .mem_rtrn_type_i ( rtrn_type   ),
    .mem_rtrn_data_i ( fill_line   ),
    .inv_idx_i       ( inv_idx     ),
    .inv_all_i       ( inv_all     ),
    .inv_way_vld_i   ( inv_way_vld ),
    .inv_way_i       ( inv_way     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // 16-bit galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | lfsr_state[0];
    end
  endtask

  // memory content rule
  function automatic icache_pkg::fetch_t expected_word(input icache_pkg::paddr_t a);
    return {a[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'hC0DE0000;
  endfunction

  // nc returns the one word in every slot
  function automatic icache_pkg::line_t make_line(input icache_pkg::paddr_t a,
                                                  input logic nc);
    icache_pkg::line_t  line;
    icache_pkg::paddr_t base;
    base = {a[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    for (int k = 0; k < 4; k++) begin
      if (nc) begin
        line[k*`ICACHE_FETCH_W +: `ICACHE_FETCH_W] = expected_word(a);
      end else begin
        line[k*`ICACHE_FETCH_W +: `ICACHE_FETCH_W] = expected_word(base + 4 * k);
      end
    end
    return line;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Fail %s: expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic report_test(input string name, input int errs_start);
    test_count++;
    if (error_count == errs_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, error_count - errs_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock, memory model, monitors
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod/2) clk_i = ~clk_i;
  end

  // ack 1 to 4 cycles into mem_req_o and fill in the cycle after the ack
  initial begin : memory_model
    int delay;
    mem_ack   = 1'b0;
    fill_vld  = 1'b0;
    fill_line = '0;
    forever begin
      @(negedge clk_i);
      if (mem_req) begin
        req_count++;
        last_nc   = mem_nc;
        last_way  = mem_way;
        last_addr = mem_addr;
        draw_bits(2, delay);
        repeat (delay) @(negedge clk_i);
        mem_ack = 1'b1;
        @(negedge clk_i);
        mem_ack   = 1'b0;
        fill_line = make_line(mem_addr, mem_nc);
        fill_vld  = 1'b1;
        @(negedge clk_i);
        fill_vld = 1'b0;
      end
    end
  end

  // miss_o is settled a quarter period after the falling edge
  always begin : miss_monitor
    @(negedge clk_i);
    #(ClkPeriod/4);
    if (miss) begin
      miss_count++;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin : watchdog
    wait (cycle_count >= TimeoutCycles);
    $display("timeout, the tests did not finish within %0d cycles", TimeoutCycles);
    $display("TEST FAILED");
    $finish;
  end

  `include "tb_icache_tests.svh"

  initial begin : main
    en          = 1'b1;
    flush       = 1'b0;
    req         = 1'b0;
    addr        = '0;
    inv_vld     = 1'b0;
    inv_idx     = '0;
    inv_all     = 1'b0;
    inv_way_vld = 1'b0;
    inv_way     = '0;
    rst_ni      = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    // initial sweep keeps the fetch port closed
    #(ClkPeriod/4);
    check_value("ready_o", 0, ready);
    miss_then_hit();
    noncacheable_fetches();
    invalidations();
    flush_clears();
    replacement();
    back_to_back_hits();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+design
+incdir+dv
design/icache_pkg.sv
design/tag_port_if.sv
design/icache_ctrl.sv
design/tag_port_arbiter.sv
design/tag_valid_array.sv
design/data_array.sv
design/victim_select.sv
design/icache_top.sv
dv/tb_icache.sv
